//--- source/vga_pkg.sv
package vga_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Counters cover up to 2047
    localparam int COUNT_W = 11;

    // Four bits per channel, r g b
    localparam int RGB_W = 12;

    //////////////////////////////
    // 800x600 at 60 Hz, 40 MHz pixel clock
    //////////////////////////////

    // Horizontal
    localparam logic [COUNT_W-1:0] H_ACTIVE     = 11'd800;
    localparam logic [COUNT_W-1:0] H_SYNC_START = 11'd840;
    localparam logic [COUNT_W-1:0] H_SYNC_END   = 11'd968;
    localparam logic [COUNT_W-1:0] H_TOTAL      = 11'd1056;

    // Vertical
    localparam logic [COUNT_W-1:0] V_ACTIVE     = 11'd600;
    localparam logic [COUNT_W-1:0] V_SYNC_START = 11'd601;
    localparam logic [COUNT_W-1:0] V_SYNC_END   = 11'd605;
    localparam logic [COUNT_W-1:0] V_TOTAL      = 11'd628;

endpackage

//--- source/plot_pkg.sv
package plot_pkg;

    //////////////////////////////
    // Plot window geometry
    //////////////////////////////

    localparam logic [10:0] PLOT_WIDTH  = 11'd512;
    localparam logic [10:0] PLOT_HEIGHT = 11'd256;

    // Grid line spacing, both axes
    localparam logic [10:0] GRID_STEP = 11'd64;

    //////////////////////////////
    // Sample store
    //////////////////////////////

    localparam int SAMPLE_W      = 8;
    localparam int SAMPLE_COUNT  = 256;
    localparam int SAMPLE_ADDR_W = 8;

    //////////////////////////////
    // Colours, 12'hrgb
    //////////////////////////////

    localparam logic [11:0] BG_COLOUR    = 12'h113;
    localparam logic [11:0] FRAME_COLOUR = 12'hfa0;
    localparam logic [11:0] TRACE_COLOUR = 12'haa0;
    localparam logic [11:0] GRID_COLOUR  = 12'hfa0;
    localparam logic [11:0] BLANK_COLOUR = 12'h000;

endpackage

//--- source/vga_if.sv
`timescale 1ns/1ps

interface vga_if;

    // Pixel position
    logic [vga_pkg::COUNT_W-1:0] hcount;
    logic [vga_pkg::COUNT_W-1:0] vcount;

    // Sync pulses and blanking levels
    logic hsync;
    logic vsync;
    logic hblnk;
    logic vblnk;

    // Pixel colour
    logic [vga_pkg::RGB_W-1:0] rgb;

    // Producer side
    modport out (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

    // Consumer side
    modport in (input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

endinterface

//--- source/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic clk,
    input  logic rst,
    vga_if.out   out
);

    logic [vga_pkg::COUNT_W-1:0] hcount_nxt;
    logic [vga_pkg::COUNT_W-1:0] vcount_nxt;

    //////////////////////////////
    // Next counter values
    //////////////////////////////

    always_comb begin
        hcount_nxt = out.hcount + 1'b1;
        vcount_nxt = out.vcount;
        if (out.hcount == vga_pkg::H_TOTAL - 1'b1) begin
            hcount_nxt = '0;
            // Line wrap moves to the next row
            if (out.vcount == vga_pkg::V_TOTAL - 1'b1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = out.vcount + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Registered outputs
    //////////////////////////////

    // Syncs and blanking are derived from the next counts,
    // so all outputs line up in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
        end else begin
            out.hcount <= hcount_nxt;
            out.vcount <= vcount_nxt;
            out.hsync  <= (hcount_nxt >= vga_pkg::H_SYNC_START) &&
                          (hcount_nxt <  vga_pkg::H_SYNC_END);
            out.vsync  <= (vcount_nxt >= vga_pkg::V_SYNC_START) &&
                          (vcount_nxt <  vga_pkg::V_SYNC_END);
            out.hblnk  <= hcount_nxt >= vga_pkg::H_ACTIVE;
            out.vblnk  <= vcount_nxt >= vga_pkg::V_ACTIVE;
        end
    end

    // No colour at this stage
    assign out.rgb = '0;

endmodule

//--- source/sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer (
    input  logic                             clk,
    input  logic                             we,
    input  logic [plot_pkg::SAMPLE_ADDR_W-1:0] waddr,
    input  logic [plot_pkg::SAMPLE_W-1:0]      wdata,
    input  logic [plot_pkg::SAMPLE_ADDR_W-1:0] raddr,
    output logic [plot_pkg::SAMPLE_W-1:0]      rdata
);

    //////////////////////////////
    // Storage
    //////////////////////////////

    // One entry per sample, contents undefined until written
    logic [plot_pkg::SAMPLE_W-1:0] mem [plot_pkg::SAMPLE_COUNT];

    //////////////////////////////
    // Write port
    //////////////////////////////

    // A write lands on the clock edge, no handshake
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Combinational read, so the plot stage sees the
    // sample for the current column in the same cycle.
    // A write shows up from the following cycle on.
    assign rdata = mem[raddr];

endmodule

//--- source/draw_background.sv
`timescale 1ns/1ps

module draw_background (
    input  logic clk,
    input  logic rst,
    vga_if.in    in,
    vga_if.out   out
);

    logic [vga_pkg::RGB_W-1:0] rgb_nxt;

    //////////////////////////////
    // Colour select
    //////////////////////////////

    always_comb begin
        if (in.hblnk || in.vblnk) begin
            rgb_nxt = plot_pkg::BLANK_COLOUR;
        end else begin
            rgb_nxt = plot_pkg::BG_COLOUR;
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Timing passes through with one cycle of delay
    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            out.rgb    <= rgb_nxt;
        end
    end

endmodule

//--- source/draw_plot.sv
`timescale 1ns/1ps

module draw_plot #(
    parameter logic [10:0] PLOT_X = 11'd144,
    parameter logic [10:0] PLOT_Y = 11'd556
) (
    input  logic                               clk,
    input  logic                               rst,
    vga_if.in                                  in,
    vga_if.out                                 out,
    output logic [plot_pkg::SAMPLE_ADDR_W-1:0] sample_raddr,
    input  logic [plot_pkg::SAMPLE_W-1:0]      sample_rdata
);

    // Position relative to the plot origin, bottom left
    logic [vga_pkg::COUNT_W-1:0] dx;
    logic [vga_pkg::COUNT_W-1:0] dy;

    logic in_window;
    logic on_frame;
    logic on_trace;
    logic on_grid;

    logic [vga_pkg::RGB_W-1:0] rgb_nxt;

    //////////////////////////////
    // Window coordinates
    //////////////////////////////

    // Left of or below the window wraps to a large value,
    // so a single upper bound test covers both sides
    assign dx = in.hcount - PLOT_X;
    assign dy = PLOT_Y - in.vcount;

    assign in_window = (dx < plot_pkg::PLOT_WIDTH) && (dy < plot_pkg::PLOT_HEIGHT);

    // Two columns per sample
    assign sample_raddr = dx[plot_pkg::SAMPLE_ADDR_W:1];

    //////////////////////////////
    // Overlay tests
    //////////////////////////////

    assign on_frame = (dx == '0) || (dx == plot_pkg::PLOT_WIDTH - 1'b1) ||
                      (dy == '0) || (dy == plot_pkg::PLOT_HEIGHT - 1'b1);

    // dy stays below 256 inside the window
    assign on_trace = (dy == {3'b000, sample_rdata});

    assign on_grid = ((dx % plot_pkg::GRID_STEP) == '0) ||
                     ((dy % plot_pkg::GRID_STEP) == '0);

    // Later tests take priority: frame, then trace, then grid
    always_comb begin
        rgb_nxt = in.rgb;
        if (in_window) begin
            if (on_frame) begin
                rgb_nxt = plot_pkg::FRAME_COLOUR;
            end
            if (on_trace) begin
                rgb_nxt = plot_pkg::TRACE_COLOUR;
            end
            if (on_grid) begin
                rgb_nxt = plot_pkg::GRID_COLOUR;
            end
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            out.rgb    <= rgb_nxt;
        end
    end

endmodule

//--- source/plot_display_top.sv
`timescale 1ns/1ps

module plot_display_top #(
    parameter logic [10:0] PLOT_X = 11'd144,
    parameter logic [10:0] PLOT_Y = 11'd556
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               sample_we,
    input  logic [plot_pkg::SAMPLE_ADDR_W-1:0] sample_addr,
    input  logic [plot_pkg::SAMPLE_W-1:0]      sample_data,
    output logic [vga_pkg::COUNT_W-1:0]        hcount,
    output logic [vga_pkg::COUNT_W-1:0]        vcount,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               hblnk,
    output logic                               vblnk,
    output logic [vga_pkg::RGB_W-1:0]          rgb
);

    vga_if tim_bus ();
    vga_if bg_bus ();
    vga_if plot_bus ();

    logic [plot_pkg::SAMPLE_ADDR_W-1:0] sample_raddr;
    logic [plot_pkg::SAMPLE_W-1:0]      sample_rdata;

    //////////////////////////////
    // Pixel pipeline
    //////////////////////////////

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .out (tim_bus.out)
    );

    draw_background u_draw_background (
        .clk (clk),
        .rst (rst),
        .in  (tim_bus.in),
        .out (bg_bus.out)
    );

    draw_plot #(
        .PLOT_X (PLOT_X),
        .PLOT_Y (PLOT_Y)
    ) u_draw_plot (
        .clk          (clk),
        .rst          (rst),
        .in           (bg_bus.in),
        .out          (plot_bus.out),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata)
    );

    // Sample store, written from outside, read by the plot stage
    sample_buffer u_sample_buffer (
        .clk   (clk),
        .we    (sample_we),
        .waddr (sample_addr),
        .wdata (sample_data),
        .raddr (sample_raddr),
        .rdata (sample_rdata)
    );

    //////////////////////////////
    // VGA outputs
    //////////////////////////////

    assign hcount = plot_bus.hcount;
    assign vcount = plot_bus.vcount;
    assign hsync  = plot_bus.hsync;
    assign vsync  = plot_bus.vsync;
    assign hblnk  = plot_bus.hblnk;
    assign vblnk  = plot_bus.vblnk;
    assign rgb    = plot_bus.rgb;

endmodule

//--- testbench/plot_display_properties.sv
`timescale 1ns/1ps

module plot_display_properties (
    input logic                        clk,
    input logic                        rst,
    input logic [vga_pkg::COUNT_W-1:0] hcount,
    input logic                        hsync,
    input logic                        hblnk,
    input logic                        vblnk,
    input logic [vga_pkg::RGB_W-1:0]   rgb
);

    // Counter never reaches the line length
    hcount_range: assert property (@(posedge clk) disable iff (rst)
        hcount < vga_pkg::H_TOTAL)
        else $error("hcount %0d is beyond the end of the line", hcount);

    // Sync pulse exactly inside its column window
    hsync_window: assert property (@(posedge clk) disable iff (rst)
        hsync == ((hcount >= vga_pkg::H_SYNC_START) && (hcount < vga_pkg::H_SYNC_END)))
        else $error("hsync is %0b at hcount %0d", hsync, hcount);

    // No colour during blanking
    blank_black: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |-> (rgb == '0))
        else $error("rgb is 'h%0h while blanking", rgb);

endmodule

//--- testbench/plot_display_checker.sv
`timescale 1ns/1ps

module plot_display_checker #(
    parameter int PLOT_X = 144,
    parameter int PLOT_Y = 556
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               sample_we,
    input  logic [plot_pkg::SAMPLE_ADDR_W-1:0] sample_addr,
    input  logic [plot_pkg::SAMPLE_W-1:0]      sample_data,
    input  logic [vga_pkg::COUNT_W-1:0]        hcount,
    input  logic [vga_pkg::COUNT_W-1:0]        vcount,
    input  logic                               hsync,
    input  logic                               vsync,
    input  logic                               hblnk,
    input  logic                               vblnk,
    input  logic [vga_pkg::RGB_W-1:0]          rgb,
    output int                                 error_count,
    output int                                 frames_checked
);

    //////////////////////////////
    // Reference values, 800x600 at 60 Hz
    //////////////////////////////

    localparam int H_ACTIVE = 800;
    localparam int H_TOTAL  = 1056;
    localparam int V_ACTIVE = 600;
    localparam int V_TOTAL  = 628;
    localparam int PLOT_W   = 512;
    localparam int PLOT_H   = 256;
    localparam int GRID     = 64;

    localparam int BG_RGB    = 'h113;
    localparam int FRAME_RGB = 'hfa0;
    localparam int TRACE_RGB = 'haa0;
    localparam int GRID_RGB  = 'hfa0;

    logic [7:0] shadow [256];
    int         write_count = 0;
    logic       checking = 1'b0;
    logic       have_prev = 1'b0;
    logic       reset_seen = 1'b0;
    int         prev_h;
    int         prev_v;

    initial begin
        error_count = 0;
        frames_checked = 0;
    end

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            error_count = error_count + 1;
            $display("Fail %s: got 'h%0h, expected 'h%0h at hcount %0d vcount %0d",
                     name, got, expected, hcount, vcount);
        end
    endtask

    // Colour of one pixel: blanking, background, then frame, trace and grid
    function automatic int expected_rgb(input int h, input int v);
        int dx;
        int dy;
        int colour;
        dx = h - PLOT_X;
        dy = PLOT_Y - v;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return 0;
        end
        colour = BG_RGB;
        if (dx >= 0 && dx < PLOT_W && dy >= 0 && dy < PLOT_H) begin
            if (dx == 0 || dx == PLOT_W - 1 || dy == 0 || dy == PLOT_H - 1) begin
                colour = FRAME_RGB;
            end
            if (dy == int'(shadow[8'(dx / 2)])) begin
                colour = TRACE_RGB;
            end
            if (dx % GRID == 0 || dy % GRID == 0) begin
                colour = GRID_RGB;
            end
        end
        return colour;
    endfunction

    task automatic check_pixel();
        int h;
        int v;
        int exp_h;
        int exp_v;
        h = int'(hcount);
        v = int'(vcount);
        // Raster order from one output pixel to the next
        if (have_prev) begin
            exp_h = (prev_h == H_TOTAL - 1) ? 0 : prev_h + 1;
            exp_v = prev_v;
            if (prev_h == H_TOTAL - 1) begin
                exp_v = (prev_v == V_TOTAL - 1) ? 0 : prev_v + 1;
            end
            check_value("hcount", h, exp_h);
            check_value("vcount", v, exp_v);
        end
        check_value("hblnk", int'(hblnk), int'(h >= H_ACTIVE));
        check_value("vblnk", int'(vblnk), int'(v >= V_ACTIVE));
        check_value("hsync", int'(hsync), int'(h >= 840 && h < 968));
        check_value("vsync", int'(vsync), int'(v >= 601 && v < 605));
        check_value("rgb", int'(rgb), expected_rgb(h, v));
        if (h == H_TOTAL - 1 && v == V_TOTAL - 1) begin
            frames_checked = frames_checked + 1;
        end
        prev_h = h;
        prev_v = v;
        have_prev = 1'b1;
    endtask

    task automatic check_reset_state();
        check_value("hcount", int'(hcount), 0);
        check_value("vcount", int'(vcount), 0);
        check_value("hsync", int'(hsync), 0);
        check_value("vsync", int'(vsync), 0);
        check_value("hblnk", int'(hblnk), 0);
        check_value("vblnk", int'(vblnk), 0);
        check_value("rgb", int'(rgb), 0);
    endtask

    //////////////////////////////
    // Sampling on the falling edge
    //////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            reset_seen <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            if (reset_seen) begin
                check_reset_state();
            end
        end else begin
            // Inputs here are what the DUT latches on the next rising edge
            if (sample_we) begin
                shadow[sample_addr] = sample_data;
                write_count = write_count + 1;
            end
            // Start at the top left pixel once the buffer is full
            if (!checking && write_count >= plot_pkg::SAMPLE_COUNT && !sample_we &&
                hcount == '0 && vcount == '0) begin
                checking = 1'b1;
            end
            if (checking) begin
                check_pixel();
            end
        end
    end

endmodule

//--- testbench/plot_display_tb.sv
`timescale 1ns/1ps

module plot_display_tb;

    localparam int PLOT_X  = 144;
    localparam int PLOT_Y  = 556;
    localparam int SAMPLES = plot_pkg::SAMPLE_COUNT;
    localparam int FRAME_CYCLES = 1056 * 628;

    // Reset, one write per sample, three frames and some slack
    localparam int TIMEOUT_CYCLES = 16 + SAMPLES + 3 * FRAME_CYCLES + 1000;

    logic                               clk;
    logic                               rst;
    logic                               sample_we;
    logic [plot_pkg::SAMPLE_ADDR_W-1:0] sample_addr;
    logic [plot_pkg::SAMPLE_W-1:0]      sample_data;
    logic [vga_pkg::COUNT_W-1:0]        hcount;
    logic [vga_pkg::COUNT_W-1:0]        vcount;
    logic                               hsync;
    logic                               vsync;
    logic                               hblnk;
    logic                               vblnk;
    logic [vga_pkg::RGB_W-1:0]          rgb;

    int   check_errors;
    int   frames_checked;
    int   timeout_errors = 0;
    int   cycle_count = 0;
    logic timed_out = 1'b0;

    // Stimulus table, one row per write: address and sample value
    logic [7:0] addr_table [SAMPLES];
    logic [7:0] data_table [SAMPLES];

    plot_display_top #(
        .PLOT_X (11'(PLOT_X)),
        .PLOT_Y (11'(PLOT_Y))
    ) u_plot_display_top (
        .clk         (clk),
        .rst         (rst),
        .sample_we   (sample_we),
        .sample_addr (sample_addr),
        .sample_data (sample_data),
        .hcount      (hcount),
        .vcount      (vcount),
        .hsync       (hsync),
        .vsync       (vsync),
        .hblnk       (hblnk),
        .vblnk       (vblnk),
        .rgb         (rgb)
    );

    plot_display_checker #(
        .PLOT_X (PLOT_X),
        .PLOT_Y (PLOT_Y)
    ) u_plot_display_checker (
        .clk            (clk),
        .rst            (rst),
        .sample_we      (sample_we),
        .sample_addr    (sample_addr),
        .sample_data    (sample_data),
        .hcount         (hcount),
        .vcount         (vcount),
        .hsync          (hsync),
        .vsync          (vsync),
        .hblnk          (hblnk),
        .vblnk          (vblnk),
        .rgb            (rgb),
        .error_count    (check_errors),
        .frames_checked (frames_checked)
    );

    bind plot_display_top plot_display_properties u_plot_display_properties (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .hsync  (hsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .rgb    (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            timed_out <= 1'b1;
        end
    end

    // Ramp, both extremes, grid rows, then random values.
    // Addresses step by 37 so every entry is hit once, out of order
    task automatic fill_table();
        for (int i = 0; i < SAMPLES; i++) begin
            addr_table[8'(i)] = 8'(i * 37);
            if (i < 64) begin
                data_table[8'(i)] = 8'(i * 4);
            end else if (i < 68) begin
                data_table[8'(i)] = (i % 2 == 0) ? 8'd0 : 8'd255;
            end else if (i < 72) begin
                data_table[8'(i)] = 8'((i - 68) * plot_pkg::GRID_STEP);
            end else begin
                data_table[8'(i)] = 8'($urandom);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        sample_we   = 1'b0;
        sample_addr = '0;
        sample_data = '0;
        void'($urandom(32'hfc3c));
        fill_table();

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < SAMPLES; i++) begin
            @(posedge clk);
            sample_we   <= 1'b1;
            sample_addr <= addr_table[8'(i)];
            sample_data <= data_table[8'(i)];
        end
        @(posedge clk);
        sample_we <= 1'b0;

        // Two full frames checked after the buffer is loaded
        wait (frames_checked >= 2 || timed_out);
        if (timed_out) begin
            $display("Run timed out after %0d cycles with %0d frames checked",
                     cycle_count, frames_checked);
            timeout_errors = 1;
        end

        $display("Errors: %0d pixel and timing, %0d timeout, %0d total",
                 check_errors, timeout_errors, check_errors + timeout_errors);
        if (check_errors + timeout_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/vga_pkg.sv
source/plot_pkg.sv
source/vga_if.sv
source/vga_timing.sv
source/sample_buffer.sv
source/draw_background.sv
source/draw_plot.sv
source/plot_display_top.sv
testbench/plot_display_properties.sv
testbench/plot_display_checker.sv
testbench/plot_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the plot display testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f filelist.f --top-module plot_display_tb \
    -o plot_display_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

# A run that stops on an assertion is a failed run
./obj_dir/plot_display_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
